/* credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

// Credit pool for one channel on the sending side
// Returned credits increment, a sent flit decrements by one
// Increment and decrement may land in the same cycle
module credit_counter
  import credit_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  // Returned credits
  input  wire logic    incr_valid,
  input  wire change_t incr,
  // Consume one credit
  input  wire logic    decr_valid,
  output logic         decr_ready,
  // Count loaded while reset is asserted
  input  wire credit_t initial_value,
  // Credits kept out of circulation
  input  wire credit_t withhold,
  // State without this cycle's return or withhold
  output credit_t      value,
  // Usable credit including return and withhold
  output credit_t      available
);

  // --------------------
  // Count arithmetic
  // --------------------

  credit_t incr_amt;
  credit_t value_plus_incr;
  credit_t value_next;
  logic    decr_fire;

  // Gate the return by its strobe
  assign incr_amt = incr_valid ? credit_t'(incr) : '0;

  // Value plus return never wraps in CREDIT_W bits
  // since MAX_CREDITS + MAX_RETURN stays below 2**CREDIT_W
  assign value_plus_incr = value + incr_amt;

  // Withhold floors at zero
  // Decrement left out here, else decr_ready would loop back on itself
  assign available = (value_plus_incr > withhold) ? (value_plus_incr - withhold) : '0;

  // Decrement is always one credit
  assign decr_ready = (available != '0);
  assign decr_fire  = decr_valid & decr_ready;

  assign value_next = value_plus_incr - credit_t'(decr_fire);

  // --------------------
  // Count register
  // --------------------

  // Tracks initial_value for as long as reset is held
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= initial_value;
    end else begin
      value <= value_next;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Upstream returns at most MAX_RETURN per cycle
  incr_in_range_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    incr_valid |-> (incr <= change_t'(MAX_RETURN))
  );

  // Receiver never hands back more than it was given
  // An underflow would wrap high and trip this as well
  no_overflow_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    value_next <= credit_t'(MAX_CREDITS)
  );

  // Loaded start value within the pool, checked on reset release
  initial_in_range_a : assert property (
    @(posedge clk)
    $rose(arst_n) |-> (value <= credit_t'(MAX_CREDITS))
  );

endmodule : credit_counter

`default_nettype wire

/* credit_link_tx.f */
credit_pkg.sv
link_pkg.sv
vc_if.sv
credit_counter.sv
vc_sender.sv
link_arbiter.sv
credit_link_tx.sv
tb_link_checker.sv
tb_credit_link_tx.sv

/* credit_link_tx.sv */
`timescale 1ns/1ps
`default_nettype none

// Transmit side of a two-channel credit link
module credit_link_tx
  import credit_pkg::*;
  import link_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  // --------------------
  // Channel 0
  // --------------------
  input  wire logic    push_0,
  input  wire flit_t   push_flit_0,
  output logic         full_0,
  input  wire logic    ret_valid_0,
  input  wire change_t ret_count_0,
  input  wire credit_t init_credits_0,
  input  wire credit_t withhold_0,
  output credit_t      credit_value_0,
  // --------------------
  // Channel 1
  // --------------------
  input  wire logic    push_1,
  input  wire flit_t   push_flit_1,
  output logic         full_1,
  input  wire logic    ret_valid_1,
  input  wire change_t ret_count_1,
  input  wire credit_t init_credits_1,
  input  wire credit_t withhold_1,
  output credit_t      credit_value_1,
  // Registered link
  output logic         link_valid,
  output vc_id_t       link_vc,
  output flit_t        link_flit
);

  // Channel to arbiter buses
  vc_if vc0_if ();
  vc_if vc1_if ();

  vc_sender i_sender_0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (push_0),
    .push_flit    (push_flit_0),
    .full         (full_0),
    .ret_valid    (ret_valid_0),
    .ret_count    (ret_count_0),
    .init_credits (init_credits_0),
    .withhold     (withhold_0),
    .credit_value (credit_value_0),
    .arb          (vc0_if.sender)
  );

  vc_sender i_sender_1 (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (push_1),
    .push_flit    (push_flit_1),
    .full         (full_1),
    .ret_valid    (ret_valid_1),
    .ret_count    (ret_count_1),
    .init_credits (init_credits_1),
    .withhold     (withhold_1),
    .credit_value (credit_value_1),
    .arb          (vc1_if.sender)
  );

  link_arbiter i_arbiter (
    .clk        (clk),
    .arst_n     (arst_n),
    .vc0        (vc0_if.arbiter),
    .vc1        (vc1_if.arbiter),
    .link_valid (link_valid),
    .link_vc    (link_vc),
    .link_flit  (link_flit)
  );

endmodule : credit_link_tx

`default_nettype wire

/* credit_pkg.sv */
`default_nettype none

// Credit accounting definitions shared by the channel senders

package credit_pkg;

  // --------------------
  // Credit limits
  // --------------------

  // Inclusive maximum credit count held by one channel
  localparam int MAX_CREDITS = 8;

  // Inclusive maximum credits returned per cycle per channel
  localparam int MAX_RETURN = 2;

  // Widths sized to hold the inclusive maxima
  localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);
  localparam int CHANGE_W = $clog2(MAX_RETURN + 1);

  // --------------------
  // Types
  // --------------------

  // Credit count, withhold amount or initial value
  typedef logic [CREDIT_W-1:0] credit_t;

  // Returned-credit count
  typedef logic [CHANGE_W-1:0] change_t;

endpackage : credit_pkg

`default_nettype wire

/* link_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// Two-channel round-robin arbiter driving the registered link
module link_arbiter
  import link_pkg::*;
(
  input  wire logic clk,
  input  wire logic arst_n,
  vc_if.arbiter     vc0,
  vc_if.arbiter     vc1,
  output logic      link_valid,
  output vc_id_t    link_vc,
  output flit_t     link_flit
);

  // --------------------
  // Selection
  // --------------------

  arb_state_t prio_q;
  logic       elig0;
  logic       elig1;
  logic       grant0;
  logic       grant1;
  logic       any_grant;
  logic       contention;

  // Held flit and a credit behind it
  assign elig0 = vc0.pending & vc0.can_send;
  assign elig1 = vc1.pending & vc1.can_send;

  assign contention = elig0 & elig1;

  // Lone eligible channel wins outright, priority settles ties
  assign grant0 = elig0 & (!elig1 | (prio_q == PRIO_VC0));
  assign grant1 = elig1 & (!elig0 | (prio_q == PRIO_VC1));

  assign any_grant = grant0 | grant1;

  assign vc0.grant = grant0;
  assign vc1.grant = grant1;

  // Priority moves away from the winner only on a tie
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prio_q <= PRIO_VC0;
    end else if (contention) begin
      prio_q <= (prio_q == PRIO_VC0) ? PRIO_VC1 : PRIO_VC0;
    end
  end

  // --------------------
  // Link register
  // --------------------

  // One valid cycle per granted flit, one cycle after the grant
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= any_grant;
    end
  end

  // Payload and channel tag, meaningful only with link_valid
  always_ff @(posedge clk) begin
    if (any_grant) begin
      link_vc   <= vc_id_t'(grant1);
      link_flit <= grant1 ? vc1.flit : vc0.flit;
    end
  end

  // Never both channels in one cycle
  grant_onehot_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({vc1.grant, vc0.grant})
  );

  // Grants only go to a channel that asked and holds credit
  grant_eligible_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    (vc0.grant |-> (vc0.pending && vc0.can_send)) and
    (vc1.grant |-> (vc1.pending && vc1.can_send))
  );

endmodule : link_arbiter

`default_nettype wire

/* link_pkg.sv */
`default_nettype none

// Link and flit format definitions

package link_pkg;

  // --------------------
  // Link format
  // --------------------

  // Flit payload width
  localparam int FLIT_W = 16;

  // Virtual channels sharing the link
  localparam int NUM_VC = 2;

  // Flit payload
  typedef logic [FLIT_W-1:0] flit_t;

  // Virtual channel number carried next to the flit
  typedef logic [$clog2(NUM_VC)-1:0] vc_id_t;

  // --------------------
  // Arbiter state
  // --------------------

  // Channel that wins when both are eligible
  typedef enum logic [0:0] {
    PRIO_VC0 = 1'b0,
    PRIO_VC1 = 1'b1
  } arb_state_t;

endpackage : link_pkg

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --top-module tb_credit_link_tx -f credit_link_tx.f &&
./obj_dir/Vtb_credit_link_tx | tee sim.log &&
grep -q '^\*\*\* PASSED \*\*\*$' sim.log &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* tb_credit_link_tx.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the two-channel credit link transmitter
module tb_credit_link_tx
  import credit_pkg::*;
  import link_pkg::*;
();

  // --------------------
  // Run lengths
  // --------------------

  localparam int RESET_CYCLES  = 10;
  localparam int RANDOM_CYCLES = 400;
  localparam int STALL_LIMIT   = 40;
  localparam int HOLD_CYCLES   = 8;
  localparam int FAIR_CYCLES   = 60;
  localparam int DRAIN_LIMIT   = 40;
  localparam int MARGIN        = 100;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + RANDOM_CYCLES + 3 * STALL_LIMIT
                                + 2 * HOLD_CYCLES + FAIR_CYCLES + DRAIN_LIMIT + MARGIN;

  logic    clk;
  logic    arst_n;
  logic    push_0;
  flit_t   push_flit_0;
  logic    full_0;
  logic    ret_valid_0;
  change_t ret_count_0;
  credit_t init_credits_0;
  credit_t withhold_0;
  credit_t credit_value_0;
  logic    push_1;
  flit_t   push_flit_1;
  logic    full_1;
  logic    ret_valid_1;
  change_t ret_count_1;
  credit_t init_credits_1;
  credit_t withhold_1;
  credit_t credit_value_1;
  logic    link_valid;
  vc_id_t  link_vc;
  flit_t   link_flit;

  int          chk_errors;
  int          queued_flits;
  int          tb_errors = 0;
  int          errors_seen = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count;
  logic [31:0] rng;
  // Credits spent on the link and not yet handed back
  int          owed [2];
  // 0 idle, 1 random, 2 every cycle, 3 both together once both are empty
  int          push_mode;
  int          ret_mode [2];

  credit_link_tx i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .push_0         (push_0),
    .push_flit_0    (push_flit_0),
    .full_0         (full_0),
    .ret_valid_0    (ret_valid_0),
    .ret_count_0    (ret_count_0),
    .init_credits_0 (init_credits_0),
    .withhold_0     (withhold_0),
    .credit_value_0 (credit_value_0),
    .push_1         (push_1),
    .push_flit_1    (push_flit_1),
    .full_1         (full_1),
    .ret_valid_1    (ret_valid_1),
    .ret_count_1    (ret_count_1),
    .init_credits_1 (init_credits_1),
    .withhold_1     (withhold_1),
    .credit_value_1 (credit_value_1),
    .link_valid     (link_valid),
    .link_vc        (link_vc),
    .link_flit      (link_flit)
  );

  tb_link_checker i_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .push_0         (push_0),
    .push_flit_0    (push_flit_0),
    .full_0         (full_0),
    .ret_valid_0    (ret_valid_0),
    .ret_count_0    (ret_count_0),
    .init_credits_0 (init_credits_0),
    .withhold_0     (withhold_0),
    .credit_value_0 (credit_value_0),
    .push_1         (push_1),
    .push_flit_1    (push_flit_1),
    .full_1         (full_1),
    .ret_valid_1    (ret_valid_1),
    .ret_count_1    (ret_count_1),
    .init_credits_1 (init_credits_1),
    .withhold_1     (withhold_1),
    .credit_value_1 (credit_value_1),
    .link_valid     (link_valid),
    .link_vc        (link_vc),
    .link_flit      (link_flit),
    .error_count    (chk_errors),
    .queued_flits   (queued_flits)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Never hand back more than the link has spent, at most MAX_RETURN
  function automatic int return_amount(input int owed_now, input int mode,
                                       input logic [31:0] r);
    int limit;
    limit = (owed_now < MAX_RETURN) ? owed_now : MAX_RETURN;
    if (mode == 2) begin
      return limit;
    end
    if (mode == 1) begin
      return int'(r[31:24]) % (limit + 1);
    end
    return 0;
  endfunction

  // One cycle, all inputs change on the falling edge
  task automatic step();
    logic [31:0] r [2];
    int          amount [2];
    @(negedge clk);
    // Each flit on the link owes its channel one credit
    if (link_valid) begin
      owed[link_vc] = owed[link_vc] + 1;
    end
    for (int n = 0; n < 2; n++) begin
      rng       = lcg_next(rng);
      r[n]      = rng;
      amount[n] = return_amount(owed[n], ret_mode[n], rng);
      owed[n]   = owed[n] - amount[n];
    end
    push_0      = !full_0 && (push_mode == 2 || (push_mode == 1 && r[0][7])
                              || (push_mode == 3 && !full_1));
    push_flit_0 = r[0][23:8];
    ret_valid_0 = (amount[0] != 0);
    ret_count_0 = change_t'(amount[0]);
    push_1      = !full_1 && (push_mode == 2 || (push_mode == 1 && r[1][7])
                              || (push_mode == 3 && !full_0));
    push_flit_1 = r[1][23:8];
    ret_valid_1 = (amount[1] != 0);
    ret_count_1 = change_t'(amount[1]);
  endtask

  task automatic end_test(input string name);
    int now_errs;
    now_errs = tb_errors + chk_errors;
    tests_run++;
    if (now_errs != errors_seen) begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", name, now_errs - errors_seen);
    end else begin
      $display("test %-14s ok", name);
    end
    errors_seen = now_errs;
  endtask

  task automatic stuck_error(input string what);
    tb_errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int n;
    rng            = 32'h4448;
    owed[0]        = 0;
    owed[1]        = 0;
    push_mode      = 0;
    ret_mode[0]    = 0;
    ret_mode[1]    = 0;
    arst_n         = 1'b0;
    push_0         = 1'b0;
    push_flit_0    = '0;
    ret_valid_0    = 1'b0;
    ret_count_0    = '0;
    init_credits_0 = credit_t'(4);
    withhold_0     = '0;
    push_1         = 1'b0;
    push_flit_1    = '0;
    ret_valid_1    = 1'b0;
    ret_count_1    = '0;
    init_credits_1 = credit_t'(3);
    withhold_1     = '0;

    // Checker compares reset values while arst_n is low
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    end_test("reset");

    // Random pushes and returns, returns often meet a grant
    push_mode   = 1;
    ret_mode[0] = 1;
    ret_mode[1] = 1;
    withhold_0  = credit_t'(1);
    repeat (RANDOM_CYCLES) step();
    withhold_0  = '0;
    end_test("random");

    // Starve both pools, flits must stay held
    push_mode   = 2;
    ret_mode[0] = 0;
    ret_mode[1] = 0;
    n = 0;
    while (!(credit_value_0 == '0 && full_0 && credit_value_1 == '0 && full_1)
           && n < STALL_LIMIT) begin
      step();
      n++;
    end
    if (!(credit_value_0 == '0 && full_0 && credit_value_1 == '0 && full_1)) begin
      stuck_error("channels never ran out of credit with a held flit");
    end
    push_mode = 0;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      step();
      if (!full_0 || !full_1 || link_valid) begin
        stuck_error("flit left a channel with no credit");
      end
    end
    // Two credits back, all withheld, still blocked
    withhold_0  = credit_t'(2);
    ret_mode[0] = 2;
    step();
    ret_mode[0] = 0;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      step();
      if (!full_0 || link_valid) begin
        stuck_error("channel 0 sent while its credits were withheld");
      end
    end
    withhold_0 = '0;
    n = 0;
    while (full_0 && n < STALL_LIMIT) begin
      step();
      n++;
    end
    if (full_0) begin
      stuck_error("channel 0 kept its flit after the withhold was lifted");
    end
    ret_mode[0] = 2;
    ret_mode[1] = 2;
    n = 0;
    while ((full_0 || full_1) && n < STALL_LIMIT) begin
      step();
      n++;
    end
    if (full_0 || full_1) begin
      stuck_error("held flits did not leave after credits returned");
    end
    end_test("backpressure");

    // Both channels loaded in the same cycle, so every pair starts with a tie
    // The checker expects the tie winner to alternate
    push_mode = 3;
    repeat (FAIR_CYCLES) step();
    end_test("fairness");

    // Stop pushing and hand back every credit
    push_mode = 0;
    n = 0;
    while ((full_0 || full_1 || link_valid || owed[0] != 0 || owed[1] != 0)
           && n < DRAIN_LIMIT) begin
      step();
      n++;
    end
    repeat (2) step();
    if (queued_flits != 0) begin
      stuck_error($sformatf("%0d pushed flits never reached the link", queued_flits));
    end
    if (credit_value_0 != init_credits_0) begin
      tb_errors++;
      $display("[ERROR] credit_value_0: got %h, expected %h", credit_value_0, init_credits_0);
    end
    if (credit_value_1 != init_credits_1) begin
      tb_errors++;
      $display("[ERROR] credit_value_1: got %h, expected %h", credit_value_1, init_credits_1);
    end
    end_test("drain");

    $display("summary: %0d tests, %0d failed, %0d errors",
             tests_run, tests_failed, tb_errors + chk_errors);
    if (tests_failed == 0 && tb_errors + chk_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Run limit from the summed test lengths
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule : tb_credit_link_tx

`default_nettype wire

/* tb_link_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Watches the DUT ports every rising edge
// Keeps a cycle-accurate model of both credit pools and holding registers
// Grants are inferred from link_valid one cycle later
module tb_link_checker
  import credit_pkg::*;
  import link_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  input  wire logic    push_0,
  input  wire flit_t   push_flit_0,
  input  wire logic    full_0,
  input  wire logic    ret_valid_0,
  input  wire change_t ret_count_0,
  input  wire credit_t init_credits_0,
  input  wire credit_t withhold_0,
  input  wire credit_t credit_value_0,
  input  wire logic    push_1,
  input  wire flit_t   push_flit_1,
  input  wire logic    full_1,
  input  wire logic    ret_valid_1,
  input  wire change_t ret_count_1,
  input  wire credit_t init_credits_1,
  input  wire credit_t withhold_1,
  input  wire credit_t credit_value_1,
  input  wire logic    link_valid,
  input  wire vc_id_t  link_vc,
  input  wire flit_t   link_flit,
  output int           error_count,
  output int           queued_flits
);

  // Expected flits in push order per channel
  flit_t   exp_q0 [$];
  flit_t   exp_q1 [$];
  int      errs = 0;
  int      queued = 0;
  int      rst_cycles = 0;

  // Model state, value and full after the last edge
  credit_t m_value     [2];
  logic    m_full      [2];
  // Inputs and eligibility of the previous cycle
  logic    p_push      [2];
  logic    p_ret_valid [2];
  change_t p_ret       [2];
  credit_t p_withhold  [2];
  logic    p_elig      [2];
  // Samples of this cycle
  logic    s_push      [2];
  flit_t   s_flit      [2];
  logic    s_full      [2];
  logic    s_ret_valid [2];
  change_t s_ret       [2];
  credit_t s_init      [2];
  credit_t s_withhold  [2];
  credit_t s_value     [2];
  logic    g           [2];
  credit_t nv;
  credit_t av;
  flit_t   exp_flit;
  logic    have_exp;
  logic    have_tie;
  vc_id_t  last_tie_vc;

  assign error_count  = errs;
  assign queued_flits = queued;

  // --------------------
  // Reference model
  // --------------------

  // One cycle of one credit pool
  // avail is value plus return minus withhold, floored at zero
  // next value is value plus return minus the grant
  function automatic void credit_ref(
    input  credit_t value,
    input  logic    ret_valid,
    input  change_t ret,
    input  credit_t withhold,
    input  logic    grant,
    output credit_t next_value,
    output credit_t avail
  );
    int total;
    int usable;
    total  = int'(value) + (ret_valid ? int'(ret) : 0);
    usable = total - int'(withhold);
    if (usable < 0) begin
      usable = 0;
    end
    next_value = credit_t'(total - (grant ? 1 : 0));
    avail      = credit_t'(usable);
  endfunction

  task automatic value_error(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    errs++;
    $display("[ERROR] %s at %0t: got %h, expected %h", name, $time, got, exp);
  endtask

  task automatic rule_error(input string what);
    errs++;
    $display("error at %0t: %s", $time, what);
  endtask

  // --------------------
  // Compare process
  // --------------------

  always @(posedge clk) begin
    // Pre-edge values, stable since the falling edge
    s_push[0]      = push_0;
    s_push[1]      = push_1;
    s_flit[0]      = push_flit_0;
    s_flit[1]      = push_flit_1;
    s_full[0]      = full_0;
    s_full[1]      = full_1;
    s_ret_valid[0] = ret_valid_0;
    s_ret_valid[1] = ret_valid_1;
    s_ret[0]       = ret_count_0;
    s_ret[1]       = ret_count_1;
    s_init[0]      = init_credits_0;
    s_init[1]      = init_credits_1;
    s_withhold[0]  = withhold_0;
    s_withhold[1]  = withhold_1;
    s_value[0]     = credit_value_0;
    s_value[1]     = credit_value_1;

    if (!arst_n) begin
      rst_cycles++;
      exp_q0.delete();
      exp_q1.delete();
      have_tie = 1'b0;
      for (int n = 0; n < 2; n++) begin
        m_value[n]     = s_init[n];
        m_full[n]      = 1'b0;
        p_push[n]      = 1'b0;
        p_ret_valid[n] = 1'b0;
        p_ret[n]       = '0;
        p_withhold[n]  = s_withhold[n];
        p_elig[n]      = 1'b0;
        // First edge may land before the flops have seen reset
        if (rst_cycles >= 2) begin
          if (s_value[n] != s_init[n]) begin
            value_error($sformatf("credit_value_%0d", n), 16'(s_value[n]), 16'(s_init[n]));
          end
          if (s_full[n]) begin
            value_error($sformatf("full_%0d", n), 16'(s_full[n]), 16'h0);
          end
        end
      end
      if (rst_cycles >= 2 && link_valid) begin
        value_error("link_valid", 16'(link_valid), 16'h0);
      end
    end else begin
      // Grant of the previous cycle shows up on the link now
      g[0] = link_valid && (link_vc == vc_id_t'(0));
      g[1] = link_valid && (link_vc == vc_id_t'(1));

      if (link_valid) begin
        have_exp = 1'b0;
        if (g[0] && exp_q0.size() != 0) begin
          exp_flit = exp_q0.pop_front();
          have_exp = 1'b1;
        end else if (g[1] && exp_q1.size() != 0) begin
          exp_flit = exp_q1.pop_front();
          have_exp = 1'b1;
        end
        if (!have_exp) begin
          rule_error($sformatf("flit on channel %0d with nothing pushed", link_vc));
        end else if (link_flit != exp_flit) begin
          value_error($sformatf("link_flit_vc%0d", link_vc), link_flit, exp_flit);
        end
        if (!p_elig[link_vc]) begin
          rule_error($sformatf("channel %0d sent without a held flit and a credit", link_vc));
        end
        // Ties must go to the channel that lost the last tie
        if (p_elig[0] && p_elig[1]) begin
          if (have_tie && link_vc == last_tie_vc) begin
            value_error("link_vc", 16'(link_vc), 16'(!last_tie_vc));
          end
          have_tie    = 1'b1;
          last_tie_vc = link_vc;
        end
      end else if (p_elig[0] || p_elig[1]) begin
        rule_error("no flit sent although a channel could send");
      end

      for (int n = 0; n < 2; n++) begin
        // State after the edge that closed the previous cycle
        credit_ref(m_value[n], p_ret_valid[n], p_ret[n], p_withhold[n], g[n], nv, av);
        m_value[n] = nv;
        m_full[n]  = p_push[n] ? 1'b1 : (g[n] ? 1'b0 : m_full[n]);
        if (s_value[n] != m_value[n]) begin
          value_error($sformatf("credit_value_%0d", n), 16'(s_value[n]), 16'(m_value[n]));
        end
        if (s_full[n] != m_full[n]) begin
          value_error($sformatf("full_%0d", n), 16'(s_full[n]), 16'(m_full[n]));
        end
        // Eligibility of this cycle, judged at the next edge
        credit_ref(m_value[n], s_ret_valid[n], s_ret[n], s_withhold[n], 1'b0, nv, av);
        p_elig[n]      = m_full[n] && (av != '0);
        p_push[n]      = s_push[n];
        p_ret_valid[n] = s_ret_valid[n];
        p_ret[n]       = s_ret[n];
        p_withhold[n]  = s_withhold[n];
      end

      if (s_push[0]) begin
        exp_q0.push_back(s_flit[0]);
      end
      if (s_push[1]) begin
        exp_q1.push_back(s_flit[1]);
      end
    end
    queued = exp_q0.size() + exp_q1.size();
  end

endmodule : tb_link_checker

`default_nettype wire

/* vc_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Channel sender to link arbiter connection
interface vc_if
  import link_pkg::*;
();

  // Holding register is full
  logic  pending;

  // Held payload, valid while pending
  flit_t flit;

  // At least one credit available this cycle
  logic  can_send;

  // Flit and one credit are taken at the next edge
  logic  grant;

  // Channel side
  modport sender (
    output pending,
    output flit,
    output can_send,
    input  grant
  );

  // Arbiter side
  modport arbiter (
    input  pending,
    input  flit,
    input  can_send,
    output grant
  );

endinterface : vc_if

`default_nettype wire

/* vc_sender.sv */
`timescale 1ns/1ps
`default_nettype none

// One virtual channel on the transmit side
// Holds a single flit until the arbiter grants it
module vc_sender
  import credit_pkg::*;
  import link_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  // Upstream load, legal only while full is low
  input  wire logic    push,
  input  wire flit_t   push_flit,
  output logic         full,
  // Credit return from the receiver
  input  wire logic    ret_valid,
  input  wire change_t ret_count,
  input  wire credit_t init_credits,
  input  wire credit_t withhold,
  output credit_t      credit_value,
  // Toward the link arbiter
  vc_if.sender         arb
);

  // --------------------
  // Holding register
  // --------------------

  logic  full_q;
  flit_t flit_q;
  logic  credit_take;

  // Push and grant never coincide, a grant needs a held flit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (arb.grant) begin
      full_q <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (push) begin
      flit_q <= push_flit;
    end
  end

  assign full        = full_q;
  assign arb.pending = full_q;
  assign arb.flit    = flit_q;

  // --------------------
  // Credits
  // --------------------

  // Pending flit spends its credit only at the edge it is granted
  assign credit_take = full_q & arb.grant;

  credit_counter i_credit_counter (
    .clk           (clk),
    .arst_n        (arst_n),
    .incr_valid    (ret_valid),
    .incr          (ret_count),
    .decr_valid    (credit_take),
    .decr_ready    (arb.can_send),
    .initial_value (init_credits),
    .withhold      (withhold),
    .value         (credit_value),
    .available     ()
  );

  // Upstream respects full
  no_push_when_full_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    push |-> !full_q
  );

  // Arbiter only grants a held flit with a credit behind it
  grant_legal_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    arb.grant |-> (full_q && arb.can_send)
  );

endmodule : vc_sender

`default_nettype wire
